/* bench/complex_trace.txt */
# t name | w ctrl_addr ctrl_wdata | b back-pressure 0 or 1 | r eight samples | e output count
# All numbers are hex and samples are 16-bit two's complement
t reset_no_routes
r 0001 0002 0003 0004 0005 0006 0007 0008
e 0
t scaling
w 00 00000180
w 01 00000010
w 02 00007000
w 05 12345678
w 10 00000811
w 11 00000a22
w 12 00000d33
w 13 00000f44
r 0100 ff00 0200 fe00 0040 ffc0 1000 f000
e 4
t clamping
w 00 00000200
w 02 00000400
r 4000 ffff c000 0000 0000 0001 0100 8000
e 4
t routing
w 10 00000903
w 11 00000255
w 12 00000977
w 13 00000e88
r 0010 0020 0030 0040 0050 0060 0070 0080
e 3
t back_pressure
b 1
w 02 00007000
r 1234 edcc 0777 f889 2000 e000 0101 fefe
e 3
t persistence
r 0005 fffb 0123 fedd 3000 d000 0042 ffbe
e 3
w 01 0000ff00
r 0005 fffb 0123 fedd 3000 d000 0042 ffbe
e 3
b 0

/* bench/core_complex_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module core_complex_tb;

    localparam int CTRL_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 400;

    logic                        core_clock;
    logic                        arst_n;
    logic                        ctrl_req;
    logic [`CTRL_ADDR_WIDTH-1:0] ctrl_addr;
    logic [`CTRL_DATA_WIDTH-1:0] ctrl_wdata;
    logic                        ctrl_ack;
    logic                        start;
    logic                        in_valid;
    logic [`DATA_WIDTH-1:0]      in_data;
    logic                        in_ready;
    logic                        out_valid;
    logic [`DATA_WIDTH-1:0]      out_data;
    logic [7:0]                  out_tag;
    logic                        out_ready;
    logic                        done;

    // Reference copies of gain, offset, limit and the routing table
    logic signed [`DATA_WIDTH-1:0] model_const [`N_CONSTANTS];
    logic [11:0]                   model_route [`N_ROUTES];
    logic [`DATA_WIDTH-1:0]        run_samples [`N_SAMPLES];

    string       test_name;
    logic [31:0] lfsr;
    logic        back_pressure;
    int          out_count;
    int          value_errors;
    int          other_errors;
    int          timeouts;

    core_complex core_complex_i (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .ctrl_req   (ctrl_req),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_ack   (ctrl_ack),
        .start      (start),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_tag    (out_tag),
        .out_ready  (out_ready),
        .done       (done)
    );

    always #4 core_clock = ~core_clock;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Gain has 8 fraction bits and the sum wraps at 18 bits before the clamp
    function automatic logic [`DATA_WIDTH-1:0] expected_result(input logic signed [15:0] x);
        int                 scaled;
        int                 limit;
        logic signed [17:0] sum;
        scaled = (int'(x) * int'(model_const[0])) >>> 8;
        sum = 18'(scaled + int'(model_const[1]));
        limit = int'(model_const[2]);
        if (sum > limit) begin
            return limit[15:0];
        end else if (sum < -limit) begin
            return 16'(-limit);
        end
        return sum[15:0];
    endfunction

    function automatic string strip_line_end(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r")) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERR %0s %0s: expected %h, got %h", test_name, what, expected, actual);
        value_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure in %0s: %0s", test_name, what);
        other_errors++;
    endtask

    task automatic ctrl_write(input logic [7:0] addr, input logic [31:0] data);
        int waited;
        ctrl_req = 1'b1;
        ctrl_addr = addr;
        ctrl_wdata = data;
        waited = 0;
        while (!ctrl_ack && waited < CTRL_TIMEOUT) begin
            @(negedge core_clock);
            waited++;
        end
        if (!ctrl_ack) begin
            $display("Timeout: ctrl_ack never rose for control address %h", addr);
            timeouts++;
        end else if (waited != 1) begin
            report_mismatch("ctrl_ack latency", 1, waited);
        end
        ctrl_req = 1'b0;
        waited = 0;
        while (ctrl_ack && waited < CTRL_TIMEOUT) begin
            @(negedge core_clock);
            waited++;
        end
        if (ctrl_ack) begin
            $display("Timeout: ctrl_ack never fell for control address %h", addr);
            timeouts++;
        end
        if (addr < `N_CONSTANTS) begin
            model_const[addr[1:0]] = data[15:0];
        end else if (addr >= `CTRL_ROUTE_BASE && addr < `CTRL_ROUTE_BASE + `N_ROUTES) begin
            model_route[addr - `CTRL_ROUTE_BASE] = data[11:0];
        end
    endtask

    task automatic process_run();
        logic [`DATA_WIDTH-1:0] exp_data [$];
        logic [7:0]             exp_tag [$];
        logic [`DATA_WIDTH-1:0] held_data;
        logic [7:0]             held_tag;
        logic                   held;
        logic                   finished;
        int                     next_sample;
        int                     waited;
        for (int i = 0; i < `N_ROUTES; i++) begin
            if (model_route[i][11]) begin
                exp_data.push_back(expected_result(run_samples[model_route[i][10:8]]));
                exp_tag.push_back(model_route[i][7:0]);
            end
        end
        out_count = 0;
        held = 1'b0;
        finished = 1'b0;
        next_sample = 0;
        waited = 0;
        start = 1'b1;
        @(negedge core_clock);
        start = 1'b0;
        while (!finished && waited < RUN_TIMEOUT) begin
            if (done) begin
                finished = 1'b1;
            end else begin
                if (held && !out_valid) begin
                    report_failure("out_valid dropped before the output was accepted");
                end
                if (held && out_valid && out_data !== held_data) begin
                    report_mismatch("held out_data", held_data, out_data);
                end
                if (held && out_valid && out_tag !== held_tag) begin
                    report_mismatch("held out_tag", held_tag, out_tag);
                end
                if (back_pressure) begin
                    out_ready = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                end else begin
                    out_ready = 1'b1;
                end
                held = out_valid && !out_ready;
                held_data = out_data;
                held_tag = out_tag;
                if (out_valid && out_ready && out_count >= exp_data.size()) begin
                    report_failure("an output appeared beyond the expected list");
                end else if (out_valid && out_ready) begin
                    if (out_data !== exp_data[out_count]) begin
                        report_mismatch($sformatf("out_data %0d", out_count),
                                        exp_data[out_count], out_data);
                    end
                    if (out_tag !== exp_tag[out_count]) begin
                        report_mismatch($sformatf("out_tag %0d", out_count),
                                        exp_tag[out_count], out_tag);
                    end
                end
                if (out_valid && out_ready) begin
                    out_count++;
                end
                // in_ready depends only on the sequencer state, so it holds until the next edge
                if (next_sample < `N_SAMPLES) begin
                    in_valid = 1'b1;
                    in_data = run_samples[next_sample];
                    if (in_ready) begin
                        next_sample++;
                    end
                end else begin
                    in_valid = 1'b0;
                end
                @(negedge core_clock);
                waited++;
            end
        end
        in_valid = 1'b0;
        out_ready = 1'b0;
        if (!finished) begin
            $display("Timeout: %0s never reached done", test_name);
            timeouts++;
        end else begin
            // The sequencer goes back to idle on the edge that ends the done pulse
            @(negedge core_clock);
            if (done !== 1'b0) begin
                report_mismatch("done pulse width", 0, done);
            end
            if (next_sample != `N_SAMPLES) begin
                report_mismatch("accepted samples", `N_SAMPLES, next_sample);
            end
            if (out_count != exp_data.size()) begin
                report_mismatch("output count", exp_data.size(), out_count);
            end
        end
    endtask

    task automatic apply_trace_line(input string line);
        string       body;
        logic [31:0] first;
        logic [31:0] second;
        int          fields;
        body = line.substr(1, line.len() - 1);
        case (line.getc(0))
            "t": begin
                test_name = line.substr(2, line.len() - 1);
            end
            "w": begin
                fields = $sscanf(body, "%h %h", first, second);
                if (fields != 2) begin
                    report_failure("malformed control write in the trace");
                end else begin
                    ctrl_write(first[7:0], second);
                end
            end
            "b": begin
                fields = $sscanf(body, "%h", first);
                back_pressure = first[0];
            end
            "r": begin
                fields = $sscanf(body, "%h %h %h %h %h %h %h %h",
                                 run_samples[0], run_samples[1], run_samples[2],
                                 run_samples[3], run_samples[4], run_samples[5],
                                 run_samples[6], run_samples[7]);
                if (fields != `N_SAMPLES) begin
                    report_failure("a run line in the trace does not hold eight samples");
                end else begin
                    process_run();
                end
            end
            "e": begin
                fields = $sscanf(body, "%h", first);
                if (out_count != first) begin
                    report_mismatch("output count marker", first, out_count);
                end
            end
            "#": begin
            end
            default: begin
                report_failure("unknown command in the trace");
            end
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        core_clock = 1'b0;
        arst_n = 1'b0;
        ctrl_req = 1'b0;
        ctrl_addr = '0;
        ctrl_wdata = '0;
        start = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        lfsr = 32'h5b58_85a0;
        back_pressure = 1'b0;
        out_count = 0;
        value_errors = 0;
        other_errors = 0;
        timeouts = 0;
        test_name = "reset";
        for (int i = 0; i < `N_CONSTANTS; i++) begin
            model_const[i] = '0;
        end
        for (int i = 0; i < `N_ROUTES; i++) begin
            model_route[i] = '0;
        end
        repeat (10) @(negedge core_clock);
        arst_n = 1'b1;
        @(negedge core_clock);
        if (ctrl_ack !== 1'b0) begin
            report_mismatch("ctrl_ack", 0, ctrl_ack);
        end
        if (in_ready !== 1'b0) begin
            report_mismatch("in_ready", 0, in_ready);
        end
        if (out_valid !== 1'b0) begin
            report_mismatch("out_valid", 0, out_valid);
        end
        if (done !== 1'b0) begin
            report_mismatch("done", 0, done);
        end
        fd = $fopen("bench/complex_trace.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/complex_trace.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                if ($fgets(line, fd) > 0) begin
                    line = strip_line_end(line);
                    if (line.len() > 0) begin
                        apply_trace_line(line);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Error counts: %0d wrong values, %0d other failures, %0d timeouts",
                 value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/complex_ifaces.sv */
`timescale 1ns/100ps
`default_nettype none

// Register write channel where a transfer happens when valid and ready are both high
interface reg_write_if;
    logic                   valid;
    logic                   ready;
    complex_pkg::reg_addr_t addr;
    complex_pkg::sample_t   data;

    modport source (
        output valid,
        output addr,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  addr,
        input  data,
        output ready
    );
endinterface

// Register read channel with a fixed one cycle response
interface reg_read_if;
    logic                   req;
    complex_pkg::reg_addr_t addr;
    logic                   resp_valid;
    complex_pkg::sample_t   resp_data;

    modport requester (
        output req,
        output addr,
        input  resp_valid,
        input  resp_data
    );

    modport responder (
        input  req,
        input  addr,
        output resp_valid,
        output resp_data
    );
endinterface

`default_nettype wire

/* hw/complex_params.svh */
`ifndef COMPLEX_PARAMS_SVH
`define COMPLEX_PARAMS_SVH

`define DATA_WIDTH      16
`define CTRL_ADDR_WIDTH 8
`define CTRL_DATA_WIDTH 32
`define REG_ADDR_WIDTH  5

`define N_SAMPLES       8
`define N_ROUTES        4
`define N_CONSTANTS     3

// Register file map of the compute core
`define REG_GAIN        0
`define REG_OFFSET      1
`define REG_LIMIT       2
`define REG_INPUT_BASE  4
`define REG_RESULT_BASE 16

// Constants sit at control addresses 0 to 2 and the routing table starts here
`define CTRL_ROUTE_BASE 8'h10

`endif

/* hw/complex_pkg.sv */
`default_nettype none
`include "complex_params.svh"

package complex_pkg;

    typedef logic signed [`DATA_WIDTH-1:0] sample_t;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef struct packed {
        logic       enable;
        logic [2:0] src;
        logic [7:0] tag;
    } route_entry_t;

    // One control word is read as a constant or as a routing entry depending on the address
    typedef union packed {
        struct packed {
            logic [`CTRL_DATA_WIDTH-`DATA_WIDTH-1:0] unused;
            sample_t                                 value;
        } as_const;
        struct packed {
            logic [`CTRL_DATA_WIDTH-$bits(route_entry_t)-1:0] unused;
            route_entry_t                                     entry;
        } as_route;
    } ctrl_word_u;

endpackage

`default_nettype wire

/* hw/compute_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module compute_core (
    input  logic          core_clock,
    input  logic          arst_n,
    reg_write_if.sink     reg_wr,
    input  logic          run,
    output logic          core_done,
    reg_read_if.responder rd
);

    localparam int LAST_CYCLE = `N_SAMPLES + 1;

    complex_pkg::sample_t   rf [2**`REG_ADDR_WIDTH];
    logic                   busy;
    logic [3:0]             cycle;
    logic                   issue;
    complex_pkg::sample_t   x;
    logic                   s1_valid;
    logic [2:0]             s1_idx;
    logic signed [31:0]     s1_prod;
    logic signed [31:0]     scaled;
    logic signed [17:0]     sum;
    complex_pkg::sample_t   limit;
    complex_pkg::sample_t   clamped;
    complex_pkg::reg_addr_t res_addr;

    assign reg_wr.ready = 1'b1;

    // Stage 1 takes one input per cycle during the first N_SAMPLES cycles of a run
    assign issue = busy && (cycle < `N_SAMPLES);
    assign x = rf[complex_pkg::reg_addr_t'(`REG_INPUT_BASE + cycle[2:0])];

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cycle <= '0;
            s1_valid <= 1'b0;
            core_done <= 1'b0;
            rd.resp_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
            rd.resp_valid <= rd.req;
            core_done <= busy && (cycle == LAST_CYCLE);
            if (run) begin
                busy <= 1'b1;
                cycle <= '0;
            end else if (busy) begin
                cycle <= cycle + 1'b1;
                if (cycle == LAST_CYCLE) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge core_clock) begin
        if (issue) begin
            s1_prod <= x * rf[`REG_GAIN];
            s1_idx <= cycle[2:0];
        end
        rd.resp_data <= rf[rd.addr];
    end

    // Stage 2 scales back by 256, adds the offset and clamps symmetrically
    assign scaled = s1_prod >>> 8;
    assign sum = $signed(scaled[17:0]) + rf[`REG_OFFSET];
    assign limit = rf[`REG_LIMIT];

    always_comb begin
        if (sum > limit) begin
            clamped = limit;
        end else if (sum < -limit) begin
            clamped = -limit;
        end else begin
            clamped = sum[`DATA_WIDTH-1:0];
        end
    end

    assign res_addr = complex_pkg::reg_addr_t'(`REG_RESULT_BASE + s1_idx);

    always_ff @(posedge core_clock) begin
        if (reg_wr.valid) begin
            rf[reg_wr.addr] <= reg_wr.data;
        end
        if (s1_valid) begin
            rf[res_addr] <= clamped;
        end
    end

    // Constants and inputs below the result window stay untouched while a run is in flight
    no_low_writes_in_run: assert property (
        @(posedge core_clock) disable iff (!arst_n)
        (busy || s1_valid) |-> !reg_wr.valid
    );

endmodule

`default_nettype wire

/* hw/constant_bank.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module constant_bank (
    input  logic                 core_clock,
    input  logic                 arst_n,
    input  logic                 const_we,
    input  logic [1:0]           const_sel,
    input  complex_pkg::sample_t const_value,
    input  logic                 replay,
    reg_write_if.source          const_out
);

    complex_pkg::sample_t consts [`N_CONSTANTS];
    logic [1:0]           idx;
    logic                 active;

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            idx <= '0;
            for (int i = 0; i < `N_CONSTANTS; i++) begin
                consts[i] <= '0;
            end
        end else begin
            if (const_we) begin
                consts[const_sel] <= const_value;
            end
            if (replay) begin
                active <= 1'b1;
                idx <= '0;
            end else if (active && const_out.ready) begin
                if (idx == 2'(`N_CONSTANTS - 1)) begin
                    active <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    assign const_out.valid = active;
    assign const_out.data = consts[idx];

    // Order on the wire is gain, offset, limit
    always_comb begin
        case (idx)
            2'd0: const_out.addr = complex_pkg::reg_addr_t'(`REG_GAIN);
            2'd1: const_out.addr = complex_pkg::reg_addr_t'(`REG_OFFSET);
            default: const_out.addr = complex_pkg::reg_addr_t'(`REG_LIMIT);
        endcase
    end

endmodule

`default_nettype wire

/* hw/control_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module control_decoder (
    input  logic                        core_clock,
    input  logic                        arst_n,
    input  logic                        ctrl_req,
    input  logic [`CTRL_ADDR_WIDTH-1:0] ctrl_addr,
    input  complex_pkg::ctrl_word_u     ctrl_wdata,
    output logic                        ctrl_ack,
    output logic                        const_we,
    output logic [1:0]                  const_sel,
    output complex_pkg::sample_t        const_value,
    output complex_pkg::route_entry_t   routes [`N_ROUTES]
);

    localparam int ROUTE_IDX_W = $clog2(`N_ROUTES);

    logic                        accept;
    logic                        route_we;
    logic [`CTRL_ADDR_WIDTH-1:0] route_offset;

    // A request is taken only once the previous handshake has fully closed
    assign accept = ctrl_req && !ctrl_ack;

    assign route_offset = ctrl_addr - `CTRL_ROUTE_BASE;
    assign route_we = accept && (ctrl_addr >= `CTRL_ROUTE_BASE) && (route_offset < `N_ROUTES);

    assign const_we = accept && (ctrl_addr < `N_CONSTANTS);
    assign const_sel = ctrl_addr[1:0];
    assign const_value = ctrl_wdata.as_const.value;

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_ack <= 1'b0;
            for (int i = 0; i < `N_ROUTES; i++) begin
                routes[i] <= '0;
            end
        end else begin
            if (accept) begin
                ctrl_ack <= 1'b1;
            end else if (ctrl_ack && !ctrl_req) begin
                ctrl_ack <= 1'b0;
            end
            if (route_we) begin
                routes[route_offset[ROUTE_IDX_W-1:0]] <= ctrl_wdata.as_route.entry;
            end
        end
    end

    ack_needs_req: assert property (
        @(posedge core_clock) disable iff (!arst_n) $rose(ctrl_ack) |-> $past(ctrl_req)
    );

endmodule

`default_nettype wire

/* hw/core_complex.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module core_complex (
    input  logic                        core_clock,
    input  logic                        arst_n,
    input  logic                        ctrl_req,
    input  logic [`CTRL_ADDR_WIDTH-1:0] ctrl_addr,
    input  logic [`CTRL_DATA_WIDTH-1:0] ctrl_wdata,
    output logic                        ctrl_ack,
    input  logic                        start,
    input  logic                        in_valid,
    input  logic [`DATA_WIDTH-1:0]      in_data,
    output logic                        in_ready,
    output logic                        out_valid,
    output logic [`DATA_WIDTH-1:0]      out_data,
    output logic [7:0]                  out_tag,
    input  logic                        out_ready,
    output logic                        done
);

    logic                      const_we;
    logic [1:0]                const_sel;
    complex_pkg::sample_t      const_value;
    complex_pkg::route_entry_t routes [`N_ROUTES];
    logic                      replay;
    logic                      run;
    logic                      core_done;

    reg_write_if const_wr ();
    reg_write_if core_wr ();
    reg_read_if  result_rd ();

    control_decoder control_decoder_i (
        .core_clock  (core_clock),
        .arst_n      (arst_n),
        .ctrl_req    (ctrl_req),
        .ctrl_addr   (ctrl_addr),
        .ctrl_wdata  (ctrl_wdata),
        .ctrl_ack    (ctrl_ack),
        .const_we    (const_we),
        .const_sel   (const_sel),
        .const_value (const_value),
        .routes      (routes)
    );

    constant_bank constant_bank_i (
        .core_clock  (core_clock),
        .arst_n      (arst_n),
        .const_we    (const_we),
        .const_sel   (const_sel),
        .const_value (const_value),
        .replay      (replay),
        .const_out   (const_wr)
    );

    input_sequencer input_sequencer_i (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .start      (start),
        .done       (done),
        .replay     (replay),
        .const_in   (const_wr),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .reg_wr     (core_wr),
        .run        (run)
    );

    compute_core compute_core_i (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .reg_wr     (core_wr),
        .run        (run),
        .core_done  (core_done),
        .rd         (result_rd)
    );

    result_mover result_mover_i (
        .core_clock (core_clock),
        .arst_n     (arst_n),
        .core_done  (core_done),
        .routes     (routes),
        .rd         (result_rd),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_tag    (out_tag),
        .out_ready  (out_ready),
        .done       (done)
    );

endmodule

`default_nettype wire

/* hw/input_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module input_sequencer (
    input  logic                 core_clock,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic                 done,
    output logic                 replay,
    reg_write_if.sink            const_in,
    input  logic                 in_valid,
    input  complex_pkg::sample_t in_data,
    output logic                 in_ready,
    reg_write_if.source          reg_wr,
    output logic                 run
);

    typedef enum logic [1:0] {
        IDLE,
        REPLAY,
        LOAD,
        WAIT_DONE
    } state_t;

    state_t     state;
    logic [2:0] count;
    logic       write_done;

    assign write_done = reg_wr.valid && reg_wr.ready;

    // Only one of the two write sources reaches the core at a time
    always_comb begin
        reg_wr.valid = 1'b0;
        reg_wr.addr = const_in.addr;
        reg_wr.data = const_in.data;
        const_in.ready = 1'b0;
        in_ready = 1'b0;
        case (state)
            REPLAY: begin
                reg_wr.valid = const_in.valid;
                const_in.ready = reg_wr.ready;
            end
            LOAD: begin
                reg_wr.valid = in_valid;
                reg_wr.addr = complex_pkg::reg_addr_t'(`REG_INPUT_BASE + count);
                reg_wr.data = in_data;
                in_ready = reg_wr.ready;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            count <= '0;
            replay <= 1'b0;
            run <= 1'b0;
        end else begin
            replay <= 1'b0;
            run <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        replay <= 1'b1;
                        count <= '0;
                        state <= REPLAY;
                    end
                end
                REPLAY: begin
                    if (write_done && count == 3'(`N_CONSTANTS - 1)) begin
                        count <= '0;
                        state <= LOAD;
                    end else if (write_done) begin
                        count <= count + 1'b1;
                    end
                end
                LOAD: begin
                    if (write_done && count == 3'(`N_SAMPLES - 1)) begin
                        run <= 1'b1;
                        state <= WAIT_DONE;
                    end else if (write_done) begin
                        count <= count + 1'b1;
                    end
                end
                WAIT_DONE: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    run_after_writes: assert property (
        @(posedge core_clock) disable iff (!arst_n) run |-> !reg_wr.valid
    );

endmodule

`default_nettype wire

/* hw/result_mover.sv */
`timescale 1ns/100ps
`default_nettype none
`include "complex_params.svh"

module result_mover (
    input  logic                      core_clock,
    input  logic                      arst_n,
    input  logic                      core_done,
    input  complex_pkg::route_entry_t routes [`N_ROUTES],
    reg_read_if.requester             rd,
    output logic                      out_valid,
    output complex_pkg::sample_t      out_data,
    output logic [7:0]                out_tag,
    input  logic                      out_ready,
    output logic                      done
);

    localparam int IDX_W = $clog2(`N_ROUTES);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        PRESENT
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic [IDX_W:0]   search_base;
    logic [IDX_W-1:0] next_idx;
    logic             found;
    logic             advance;
    logic             issue;

    // Finds the first enabled entry at or after the search base
    assign search_base = (state == IDLE) ? '0 : {1'b0, idx} + 1'b1;

    always_comb begin
        found = 1'b0;
        next_idx = '0;
        for (int i = `N_ROUTES - 1; i >= 0; i--) begin
            if (i >= search_base && routes[i].enable) begin
                found = 1'b1;
                next_idx = IDX_W'(i);
            end
        end
    end

    assign advance = (state == IDLE && core_done) || (state == PRESENT && out_ready);
    assign issue = advance && found;

    always_ff @(posedge core_clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            idx <= '0;
            rd.req <= 1'b0;
            out_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            rd.req <= issue;
            done <= advance && !found;
            if (issue) begin
                idx <= next_idx;
            end
            if (advance) begin
                out_valid <= 1'b0;
                state <= found ? WAIT_RESP : IDLE;
            end else if (state == WAIT_RESP && rd.resp_valid) begin
                out_valid <= 1'b1;
                state <= PRESENT;
            end
        end
    end

    always_ff @(posedge core_clock) begin
        if (issue) begin
            rd.addr <= complex_pkg::reg_addr_t'(`REG_RESULT_BASE + routes[next_idx].src);
        end
        if (state == WAIT_RESP && rd.resp_valid) begin
            out_data <= rd.resp_data;
            out_tag <= routes[idx].tag;
        end
    end

    output_held: assert property (
        @(posedge core_clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_tag)
    );

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/complex_pkg.sv
hw/complex_ifaces.sv
hw/control_decoder.sv
hw/constant_bank.sv
hw/input_sequencer.sv
hw/compute_core.sv
hw/result_mover.sv
hw/core_complex.sv
bench/core_complex_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module core_complex_tb -Mdir build/obj_dir -o sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./build/obj_dir/sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
